/* files.f */
+incdir+verilog
+incdir+tb
verilog/mgmt_pkg.sv
verilog/die_info_regs.sv
verilog/mbist_regs.sv
verilog/mdio_channel_regs.sv
verilog/port_config_regs.sv
verilog/mgmt_register_interface.sv
tb/mgmt_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the testbench and the DUT with assertions enabled
verilator --binary --timing --assert -f files.f --top-module mgmt_tb -Mdir obj_dir -o mgmt_sim

# Nonzero exit status on any failure
./obj_dir/mgmt_sim

/* tb/mgmt_tb_tasks.svh */
`ifndef MGMT_TB_TASKS_SVH
`define MGMT_TB_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Failure handling

// Ends the run after an error line has been printed
task automatic stop_run();
	$display("Regression failed");
	$fatal(1, "Simulation stopped on the first error");
endtask

task automatic check_byte(input string what, input mgmt_data_t got, input mgmt_data_t exp);
	if (got !== exp) begin
		$display("Fail at time %0t: %s read %h, expected %h", $time, what, got, exp);
		stop_run();
	end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Fail at time %0t: %s is %b, expected %b", $time, what, got, exp);
		stop_run();
	end
endtask

task automatic check_latency(input string what, input int got, input int exp);
	if (got != exp) begin
		$display("Fail at time %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
		stop_run();
	end
endtask

task automatic check_mdio_cmd(input string what, input mdio_cmd_t got, input mdio_cmd_t exp);
	if (got !== exp) begin
		$display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
		stop_run();
	end
endtask

task automatic check_port_cfg(input string what, input port_cfg_t got, input port_cfg_t exp);
	if (got !== exp) begin
		$display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
		stop_run();
	end
endtask

task automatic check_mbist_ctl(input string what, input mbist_ctl_t got, input mbist_ctl_t exp);
	if (got !== exp) begin
		$display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
		stop_run();
	end
endtask

//////////////////////////////////////////////////////////////////////
// Host bus driver

// Single-cycle write strobe, effective at the edge it spans
task automatic write_reg(input mgmt_addr_t a, input mgmt_data_t d);
	wr_en = 1'b1;
	wr_addr = a;
	wr_data = d;
	@(posedge clk);
	#1;
	wr_en = 1'b0;
endtask

// One-cycle rd_en pulse
task automatic start_read(input mgmt_addr_t a);
	rd_en = 1'b1;
	rd_addr = a;
	@(posedge clk);
	#1;
	rd_en = 1'b0;
endtask

// Counts cycles from the rd_en edge until rd_valid
task automatic finish_read(output mgmt_data_t d, output int lat);
	lat = 1;
	while (!rd_valid) begin
		if (lat >= RD_TIMEOUT) begin
			$display("Timed out after %0d cycles waiting for rd_valid", lat);
			stop_run();
		end
		@(posedge clk);
		#1;
		lat++;
	end
	d = rd_data;
endtask

// Read whose owner is always ready
task automatic read_and_check(input mgmt_addr_t a, input mgmt_data_t exp);
	mgmt_data_t d;
	int lat;
	string what;
	what = $sformatf("read of %h", a);
	start_read(a);
	finish_read(d, lat);
	check_latency(what, lat, 1);
	check_byte(what, d, exp);
endtask

`endif

/* tb/mgmt_tb.sv */
`include "mgmt_defines.svh"

module mgmt_tb import mgmt_pkg::*; ();

	localparam int RD_TIMEOUT = 50;

	// MDIO command register base of each channel
	localparam mgmt_addr_t MDIO_BASE [`MGMT_NUM_MDIO] = '{16'h0048, 16'h004c, 16'h0050};

	logic								clk;
	logic								reset;
	logic								rd_en;
	mgmt_addr_t							rd_addr;
	logic								rd_valid;
	mgmt_data_t							rd_data;
	logic								wr_en;
	mgmt_addr_t							wr_addr;
	mgmt_data_t							wr_data;
	die_info_t							die_info;
	sensor_t							sensors;
	mdio_status_t [`MGMT_NUM_MDIO-1:0]	mdio_status;
	mdio_cmd_t [`MGMT_NUM_MDIO-1:0]		mdio_cmd;
	port_cfg_t [`MGMT_NUM_PORTS-1:0]	port_cfg;
	mbist_status_t						mbist_status;
	mbist_ctl_t							mbist_ctl;

	// Reference model of every writable register
	mdio_cmd_t		mdio_model [`MGMT_NUM_MDIO];
	port_cfg_t		port_model [`MGMT_NUM_PORTS];
	mbist_ctl_t		mbist_model;
	logic [15:0]	sen_words [6];
	logic [15:0]	lfsr_state;

	mgmt_register_interface uut (
		.clk			(clk),
		.reset			(reset),
		.rd_en			(rd_en),
		.rd_addr		(rd_addr),
		.rd_valid		(rd_valid),
		.rd_data		(rd_data),
		.wr_en			(wr_en),
		.wr_addr		(wr_addr),
		.wr_data		(wr_data),
		.die_info		(die_info),
		.sensors		(sensors),
		.mdio_status	(mdio_status),
		.mdio_cmd		(mdio_cmd),
		.port_cfg		(port_cfg),
		.mbist_status	(mbist_status),
		.mbist_ctl		(mbist_ctl)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	`include "mgmt_tb_tasks.svh"

	//////////////////////////////////////////////////////////////////////
	// Random source

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[15]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	function automatic mgmt_data_t rand_byte();
		return mgmt_data_t'(rand_bits(8));
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Model helpers

	// Expected port readback with bits where they were written
	function automatic mgmt_data_t port_byte(input logic [3:0] p, input logic [9:0] r);
		if (p >= `MGMT_NUM_PORTS)
			return '0;
		case (r)
			10'd0:		return port_model[p].vlan[7:0];
			10'd1:		return {4'h0, port_model[p].vlan[11:8]};
			10'd2: begin
				return {3'b000, port_model[p].is_trunk, 2'b00,
					port_model[p].untagged_allowed, port_model[p].tagged_allowed};
			end
			default:	return '0;
		endcase
	endfunction

	function automatic logic is_mapped(input mgmt_addr_t a);
		return (a <= 16'h000b) || (a >= 16'h0010 && a <= 16'h001b) ||
			(a >= 16'h0040 && a <= 16'h0053) || (a >= 16'h4000 && a <= 16'h7fff);
	endfunction

	task automatic apply_port_write(input logic [3:0] p, input logic [9:0] r, input mgmt_data_t d);
		if (p < `MGMT_NUM_PORTS) begin
			case (r)
				10'd0: port_model[p].vlan[7:0] = d;
				10'd1: port_model[p].vlan[11:8] = d[3:0];
				10'd2: begin
					port_model[p].tagged_allowed = d[0];
					port_model[p].untagged_allowed = d[1];
					port_model[p].is_trunk = d[4];
				end
				default: ;
			endcase
		end
	endtask

	// Every output against the model while no read is in flight
	task automatic check_outputs();
		check_flag("rd_valid while idle", rd_valid, 1'b0);
		for (int i = 0; i < `MGMT_NUM_MDIO; i++) begin
			check_mdio_cmd($sformatf("mdio_cmd[%0d]", i), mdio_cmd[i], mdio_model[i]);
		end
		for (int p = 0; p < `MGMT_NUM_PORTS; p++) begin
			check_port_cfg($sformatf("port_cfg[%0d]", p), port_cfg[p], port_model[p]);
		end
		check_mbist_ctl("mbist_ctl", mbist_ctl, mbist_model);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequences

	task automatic test_die_info();
		mgmt_data_t d;
		int lat;
		logic [2:0] j;
		die_info.idcode = rand_bits(32);
		die_info.serial[63:32] = rand_bits(32);
		die_info.serial[31:0] = rand_bits(32);
		// IDCODE byte 1 held off until the source is valid
		start_read(16'h0001);
		repeat (6) begin
			check_flag("rd_valid during IDCODE stall", rd_valid, 1'b0);
			@(posedge clk);
			#1;
		end
		die_info.idcode_valid = 1'b1;
		finish_read(d, lat);
		check_latency("stalled IDCODE read after valid", lat, 2);
		check_byte("stalled IDCODE byte 1", d, die_info.idcode[23:16]);
		@(posedge clk);
		#1;
		// Same for a random serial byte
		j = 3'(rand_bits(3));
		start_read(mgmt_addr_t'(j + 4));
		repeat (6) begin
			check_flag("rd_valid during serial stall", rd_valid, 1'b0);
			@(posedge clk);
			#1;
		end
		die_info.serial_valid = 1'b1;
		finish_read(d, lat);
		check_latency("stalled serial read after valid", lat, 2);
		check_byte("stalled serial byte", d, die_info.serial[8*(7-j) +: 8]);
		@(posedge clk);
		#1;
		// Both valid and read most significant byte first
		for (int i = 0; i < 4; i++) begin
			read_and_check(mgmt_addr_t'(i), die_info.idcode[8*(3-i) +: 8]);
		end
		for (int i = 0; i < 8; i++) begin
			read_and_check(mgmt_addr_t'(i + 4), die_info.serial[8*(7-i) +: 8]);
		end
	endtask

	task automatic test_sensors();
		for (int k = 0; k < 6; k++) begin
			sen_words[k] = 16'(rand_bits(16));
		end
		sensors = {sen_words[0], sen_words[1], sen_words[2],
			sen_words[3], sen_words[4], sen_words[5]};
		// Low byte at the lower address
		for (int k = 0; k < 12; k++) begin
			read_and_check(mgmt_addr_t'(k + 'h10),
				k[0] ? sen_words[k/2][15:8] : sen_words[k/2][7:0]);
		end
	endtask

	task automatic test_mdio_channel(input int ch);
		mgmt_addr_t base;
		mgmt_data_t b [4];
		logic is_wr;
		logic busy;
		base = MDIO_BASE[ch];
		repeat (4) begin
			for (int j = 0; j < 4; j++) begin
				b[j] = rand_byte();
			end
			// Exactly one of read or write requested
			is_wr = 1'(rand_bits(1));
			b[3][6] = is_wr;
			b[3][5] = !is_wr;
			for (int j = 0; j < 3; j++) begin
				write_reg(mgmt_addr_t'(base + j), b[j]);
			end
			mdio_model[ch].wr_data = {b[1], b[0]};
			mdio_model[ch].reg_addr = b[2][4:0];
			mdio_model[ch].phy_addr[2:0] = b[2][7:5];
			check_outputs();
			write_reg(mgmt_addr_t'(base + 3), b[3]);
			mdio_model[ch].phy_addr[4:3] = b[3][1:0];
			mdio_model[ch].rd = !is_wr;
			mdio_model[ch].wr = is_wr;
			check_outputs();
			// Strobe gone one cycle later
			mdio_model[ch].rd = 1'b0;
			mdio_model[ch].wr = 1'b0;
			@(posedge clk);
			#1;
			check_outputs();
		end
		// Busy sampled by the byte 0 read survives a later change
		busy = 1'(rand_bits(1));
		mdio_status[ch].busy = busy;
		mdio_status[ch].rd_data = 16'(rand_bits(16));
		read_and_check(base, mdio_status[ch].rd_data[7:0]);
		mdio_status[ch].busy = !busy;
		mdio_status[ch].rd_data = 16'(rand_bits(16));
		read_and_check(mgmt_addr_t'(base + 1), mdio_status[ch].rd_data[15:8]);
		read_and_check(mgmt_addr_t'(base + 2), 8'h00);
		read_and_check(mgmt_addr_t'(base + 3), {busy, 7'b0000000});
	endtask

	task automatic test_port_config();
		logic [3:0] p;
		logic [9:0] r;
		mgmt_data_t d;
		// Port 15 has no registers
		for (int i = 0; i < 3; i++) begin
			write_reg({2'b01, 4'hf, 10'(i)}, rand_byte());
			check_outputs();
			read_and_check({2'b01, 4'hf, 10'(i)}, 8'h00);
		end
		repeat (40) begin
			p = 4'(rand_bits(4));
			r = 10'(rand_bits(2));
			if (r == 10'd3)
				r = 10'd2;
			d = rand_byte();
			write_reg({2'b01, p, r}, d);
			apply_port_write(p, r, d);
			check_outputs();
			p = 4'(rand_bits(4));
			r = 10'(rand_bits(2));
			if (r == 10'd3)
				r = 10'd2;
			read_and_check({2'b01, p, r}, port_byte(p, r));
		end
	endtask

	task automatic test_mbist();
		mgmt_data_t d;
		logic sel;
		// Seed bytes go in little-endian
		for (int j = 0; j < 4; j++) begin
			d = rand_byte();
			write_reg(mgmt_addr_t'(j + 'h44), d);
			mbist_model.seed[8*j +: 8] = d;
			check_outputs();
		end
		repeat (4) begin
			sel = 1'(rand_bits(1));
			d = rand_byte();
			d[7] = sel;
			d[6] = 1'b1;
			write_reg(16'h0043, d);
			mbist_model.select = sel;
			mbist_model.start = 1'b1;
			check_outputs();
			mbist_model.start = 1'b0;
			@(posedge clk);
			#1;
			check_outputs();
			mbist_status.done = 1'(rand_bits(1));
			mbist_status.fail = 1'(rand_bits(1));
			mbist_status.fail_addr = 18'(rand_bits(18));
			read_and_check(16'h0040, mbist_status.fail_addr[7:0]);
			read_and_check(16'h0041, mbist_status.fail_addr[15:8]);
			read_and_check(16'h0042, {6'b000000, mbist_status.fail_addr[17:16]});
			read_and_check(16'h0043,
				{sel, 1'b0, mbist_status.done, mbist_status.fail, 4'b0000});
		end
		// Select alone without start
		d = rand_byte();
		d[6] = 1'b0;
		write_reg(16'h0043, d);
		mbist_model.select = d[7];
		check_outputs();
	endtask

	task automatic test_unmapped();
		mgmt_addr_t a;
		int n;
		n = 0;
		for (int tries = 0; tries < 300 && n < 30; tries++) begin
			// Mix of low addresses near the map and the full range
			a = rand_bits(1) ? 16'(rand_bits(16)) : 16'(rand_bits(7));
			if (!is_mapped(a)) begin
				write_reg(a, rand_byte());
				check_outputs();
				read_and_check(a, 8'h00);
				n++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		lfsr_state = 16'd98;
		reset = 1'b1;
		rd_en = 1'b0;
		rd_addr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		die_info = '0;
		sensors = '0;
		mdio_status = '0;
		mbist_status = '0;
		mdio_model = '{default: '0};
		port_model = '{default: '0};
		mbist_model = '0;

		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		check_outputs();
		check_byte("rd_data after reset", rd_data, 8'h00);

		test_die_info();
		test_sensors();
		for (int ch = 0; ch < `MGMT_NUM_MDIO; ch++) begin
			test_mdio_channel(ch);
		end
		test_port_config();
		test_mbist();
		test_unmapped();

		$display("Regression passed");
		$finish;
	end

endmodule

/* verilog/mgmt_register_interface.sv */
`include "mgmt_defines.svh"

module mgmt_register_interface import mgmt_pkg::*; (
	input logic									clk,
	input logic									reset,

	// Host read port
	input logic									rd_en,
	input mgmt_addr_t							rd_addr,
	output logic								rd_valid,
	output mgmt_data_t							rd_data,

	// Host write port
	input logic									wr_en,
	input mgmt_addr_t							wr_addr,
	input mgmt_data_t							wr_data,

	// Sources and controlled blocks
	input die_info_t							die_info,
	input sensor_t								sensors,
	input mdio_status_t [`MGMT_NUM_MDIO-1:0]	mdio_status,
	output mdio_cmd_t [`MGMT_NUM_MDIO-1:0]		mdio_cmd,
	output port_cfg_t [`MGMT_NUM_PORTS-1:0]		port_cfg,
	input mbist_status_t						mbist_status,
	output mbist_ctl_t							mbist_ctl
);

	localparam int CHAN_W		= $clog2(`MGMT_NUM_MDIO);
	localparam int PORT_SPAN_W	= `MGMT_PORT_BITS + `MGMT_REGID_BITS;

	// Command register base of each MDIO channel
	localparam mgmt_addr_t MDIO_BASE [`MGMT_NUM_MDIO] = '{
		REG_MGMT0_MDIO, REG_DP_MDIO, REG_VSC_MDIO
	};

	//////////////////////////////////////////////////////////////////////
	// Address decode

	function automatic region_t addr_region(input mgmt_addr_t a);
		mgmt_addr_t if_rel;
		if_rel = a - mgmt_addr_t'(`MGMT_IF_BASE);
		// Per-port blocks, 16 ports of 1K each
		if (a >= mgmt_addr_t'(`MGMT_IF_BASE))
			return (if_rel[`MGMT_ADDR_W-1:PORT_SPAN_W] == '0) ? REGION_PORT : REGION_NONE;
		if (a <= REG_FPGA_SERIAL_7)
			return REGION_INFO;
		if (a >= REG_FAN0_RPM && a <= REG_VOLT_AUX_1)
			return REGION_INFO;
		if (a >= REG_MBIST && a <= REG_MBIST_SEED_3)
			return REGION_MBIST;
		if (a >= REG_MGMT0_MDIO && a <= REG_VSC_MDIO_3)
			return REGION_MDIO;
		return REGION_NONE;
	endfunction

	// Offset relative to the owning block
	function automatic mgmt_off_t local_offset(input mgmt_addr_t a, input region_t r);
		case (r)
			REGION_PORT:	return mgmt_off_t'(a - mgmt_addr_t'(`MGMT_IF_BASE));
			REGION_MBIST:	return mgmt_off_t'(a - REG_MBIST);
			REGION_MDIO:	return mgmt_off_t'(a[1:0]);
			default:		return mgmt_off_t'(a);
		endcase
	endfunction

	function automatic logic [CHAN_W-1:0] mdio_chan(input mgmt_addr_t a);
		logic [CHAN_W-1:0] c;
		c = '0;
		for (int i = 0; i < `MGMT_NUM_MDIO; i++) begin
			if (a[`MGMT_ADDR_W-1:2] == MDIO_BASE[i][`MGMT_ADDR_W-1:2])
				c = CHAN_W'(i);
		end
		return c;
	endfunction

	rd_state_t			rd_state;
	mgmt_addr_t			rd_addr_q;
	mgmt_addr_t			rd_addr_cur;
	logic				rd_active;
	logic				owner_ready;
	logic				rd_fire;

	region_t			rd_region;
	region_t			wr_region;
	mgmt_off_t			rd_off;
	mgmt_off_t			wr_off;
	logic [CHAN_W-1:0]	rd_chan;
	logic [CHAN_W-1:0]	wr_chan;

	// Per-block accesses and their read bytes
	mgmt_access_t		info_rd;
	mgmt_access_t		mbist_rd;
	mgmt_access_t		mbist_wr;
	mgmt_access_t		port_rd;
	mgmt_access_t		port_wr;
	mgmt_access_t		mdio_rd [`MGMT_NUM_MDIO];
	mgmt_access_t		mdio_wr [`MGMT_NUM_MDIO];
	mgmt_data_t			info_data;
	mgmt_data_t			mbist_data;
	mgmt_data_t			port_data;
	mgmt_data_t			mdio_data [`MGMT_NUM_MDIO];
	mgmt_data_t			sel_byte;
	logic				info_ready;

	// A stalled read keeps using the address captured at rd_en
	assign rd_addr_cur	= (rd_state == RD_WAIT) ? rd_addr_q : rd_addr;
	assign rd_active	= rd_en || rd_state == RD_WAIT;

	assign rd_region	= addr_region(rd_addr_cur);
	assign wr_region	= addr_region(wr_addr);
	assign rd_off		= local_offset(rd_addr_cur, rd_region);
	assign wr_off		= local_offset(wr_addr, wr_region);
	assign rd_chan		= mdio_chan(rd_addr_cur);
	assign wr_chan		= mdio_chan(wr_addr);

	assign info_rd	= '{en: rd_active && rd_region == REGION_INFO, offset: rd_off, data: '0};
	assign mbist_rd	= '{en: rd_active && rd_region == REGION_MBIST, offset: rd_off, data: '0};
	assign port_rd	= '{en: rd_active && rd_region == REGION_PORT, offset: rd_off, data: '0};
	assign mbist_wr	= '{en: wr_en && wr_region == REGION_MBIST, offset: wr_off, data: wr_data};
	assign port_wr	= '{en: wr_en && wr_region == REGION_PORT, offset: wr_off, data: wr_data};

	//////////////////////////////////////////////////////////////////////
	// Register blocks

	die_info_regs u_info (
		.rd_acc		(info_rd),
		.die_info	(die_info),
		.sensors	(sensors),
		.rd_data	(info_data),
		.rd_ready	(info_ready)
	);

	mbist_regs u_mbist (
		.clk		(clk),
		.reset		(reset),
		.rd_acc		(mbist_rd),
		.wr_acc		(mbist_wr),
		.status		(mbist_status),
		.rd_data	(mbist_data),
		.ctl		(mbist_ctl)
	);

	port_config_regs u_port (
		.clk		(clk),
		.reset		(reset),
		.rd_acc		(port_rd),
		.wr_acc		(port_wr),
		.rd_data	(port_data),
		.cfg		(port_cfg)
	);

	for (genvar i = 0; i < `MGMT_NUM_MDIO; i++) begin : g_mdio
		assign mdio_rd[i] = '{
			en:		rd_active && rd_region == REGION_MDIO && rd_chan == CHAN_W'(i),
			offset:	rd_off,
			data:	'0
		};
		assign mdio_wr[i] = '{
			en:		wr_en && wr_region == REGION_MDIO && wr_chan == CHAN_W'(i),
			offset:	wr_off,
			data:	wr_data
		};

		mdio_channel_regs u_mdio (
			.clk		(clk),
			.reset		(reset),
			.rd_acc		(mdio_rd[i]),
			.wr_acc		(mdio_wr[i]),
			.status		(mdio_status[i]),
			.rd_data	(mdio_data[i]),
			.cmd		(mdio_cmd[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Read sequencing

	// Only the die info block can hold off a read
	assign owner_ready	= (rd_region == REGION_INFO) ? info_ready : 1'b1;
	assign rd_fire		= rd_active && owner_ready;

	always_comb begin
		case (rd_region)
			REGION_INFO:	sel_byte = info_data;
			REGION_MBIST:	sel_byte = mbist_data;
			REGION_MDIO:	sel_byte = mdio_data[rd_chan];
			REGION_PORT:	sel_byte = port_data;
			default:		sel_byte = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_state	<= RD_IDLE;
			rd_valid	<= 1'b0;
			rd_data		<= '0;
			rd_addr_q	<= '0;
		end else begin
			rd_valid <= rd_fire;
			if (rd_fire)
				rd_data <= sel_byte;

			case (rd_state)
				RD_IDLE: begin
					if (rd_en) begin
						rd_addr_q <= rd_addr;
						if (!owner_ready)
							rd_state <= RD_WAIT;
					end
				end
				// Hold until the source marks the byte valid
				RD_WAIT: begin
					if (owner_ready)
						rd_state <= RD_IDLE;
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		rd_valid |-> $past(rd_en || rd_state == RD_WAIT))
		else $error("rd_valid with no read in progress");

endmodule

/* verilog/port_config_regs.sv */
`include "mgmt_defines.svh"

module port_config_regs import mgmt_pkg::*; (
	input logic									clk,
	input logic									reset,
	input mgmt_access_t							rd_acc,
	input mgmt_access_t							wr_acc,
	output mgmt_data_t							rd_data,
	output port_cfg_t [`MGMT_NUM_PORTS-1:0]		cfg
);

	// Port index and register offset of each access
	logic [`MGMT_PORT_BITS-1:0]		rd_port;
	logic [`MGMT_PORT_BITS-1:0]		wr_port;
	logic [`MGMT_REGID_BITS-1:0]	rd_regid;
	logic [`MGMT_REGID_BITS-1:0]	wr_regid;

	assign rd_port	= rd_acc.offset[`MGMT_REGID_BITS +: `MGMT_PORT_BITS];
	assign wr_port	= wr_acc.offset[`MGMT_REGID_BITS +: `MGMT_PORT_BITS];
	assign rd_regid	= rd_acc.offset[`MGMT_REGID_BITS-1:0];
	assign wr_regid	= wr_acc.offset[`MGMT_REGID_BITS-1:0];

	//////////////////////////////////////////////////////////////////////
	// Configuration storage

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg <= '0;
		end

		// Indices past the last port fall through untouched
		else if (wr_acc.en && wr_port < `MGMT_NUM_PORTS) begin
			case (wr_regid)
				// VLAN number, low byte first
				REG_VLAN_NUM:	cfg[wr_port].vlan[7:0] <= wr_acc.data;
				REG_VLAN_NUM_1: begin
					cfg[wr_port].vlan[`MGMT_VLAN_W-1:8] <= wr_acc.data[`MGMT_VLAN_W-9:0];
				end
				REG_TAG_MODE: begin
					cfg[wr_port].tagged_allowed		<= wr_acc.data[0];
					cfg[wr_port].untagged_allowed	<= wr_acc.data[1];
					cfg[wr_port].is_trunk			<= wr_acc.data[4];
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Readback in the same bit positions as the write

	always_comb begin
		rd_data = '0;
		if (rd_acc.en && rd_port < `MGMT_NUM_PORTS) begin
			case (rd_regid)
				REG_VLAN_NUM:	rd_data = cfg[rd_port].vlan[7:0];
				REG_VLAN_NUM_1:	rd_data = mgmt_data_t'(cfg[rd_port].vlan[`MGMT_VLAN_W-1:8]);
				REG_TAG_MODE: begin
					rd_data = {3'b000, cfg[rd_port].is_trunk, 2'b00,
						cfg[rd_port].untagged_allowed, cfg[rd_port].tagged_allowed};
				end
				default:		rd_data = '0;
			endcase
		end
	end

endmodule

/* verilog/mdio_channel_regs.sv */
module mdio_channel_regs import mgmt_pkg::*; (
	input logic				clk,
	input logic				reset,
	input mgmt_access_t		rd_acc,
	input mgmt_access_t		wr_acc,
	input mdio_status_t		status,
	output mgmt_data_t		rd_data,
	output mdio_cmd_t		cmd
);

	// Byte lane within the 4-byte command register
	logic [1:0]	rd_byte;
	logic [1:0]	wr_byte;

	// Busy as seen by the last read of byte 0
	logic		busy_latched;

	assign rd_byte = rd_acc.offset[1:0];
	assign wr_byte = wr_acc.offset[1:0];

	//////////////////////////////////////////////////////////////////////
	// Command assembly

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd				<= '0;
			busy_latched	<= 1'b0;
		end else begin
			cmd.rd <= 1'b0;
			cmd.wr <= 1'b0;

			if (wr_acc.en) begin
				case (wr_byte)
					2'd0: cmd.wr_data[7:0]	<= wr_acc.data;
					2'd1: cmd.wr_data[15:8]	<= wr_acc.data;
					2'd2: begin
						cmd.reg_addr		<= wr_acc.data[4:0];
						cmd.phy_addr[2:0]	<= wr_acc.data[7:5];
					end
					default: begin
						cmd.phy_addr[4:3]	<= wr_acc.data[1:0];
						// Both bits set runs as a write
						cmd.rd				<= wr_acc.data[5] && !wr_acc.data[6];
						cmd.wr				<= wr_acc.data[6];
					end
				endcase
			end

			// Snapshot busy together with the read data low byte
			if (rd_acc.en && rd_byte == 2'd0)
				busy_latched <= status.busy;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Readback

	always_comb begin
		rd_data = '0;
		if (rd_acc.en) begin
			case (rd_byte)
				2'd0:		rd_data = status.rd_data[7:0];
				2'd1:		rd_data = status.rd_data[15:8];
				2'd3:		rd_data = {busy_latched, 7'b0000000};
				default:	rd_data = '0;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) !(cmd.rd && cmd.wr))
		else $error("MDIO read and write strobes together");

endmodule

/* verilog/mbist_regs.sv */
`include "mgmt_defines.svh"

module mbist_regs import mgmt_pkg::*; (
	input logic				clk,
	input logic				reset,
	input mgmt_access_t		rd_acc,
	input mgmt_access_t		wr_acc,
	input mbist_status_t	status,
	output mgmt_data_t		rd_data,
	output mbist_ctl_t		ctl
);

	// Full register addresses rebuilt from the block offsets
	mgmt_addr_t	rd_reg;
	mgmt_addr_t	wr_reg;

	assign rd_reg = REG_MBIST + mgmt_addr_t'(rd_acc.offset);
	assign wr_reg = REG_MBIST + mgmt_addr_t'(wr_acc.offset);

	//////////////////////////////////////////////////////////////////////
	// Control register and seed

	always_ff @(posedge clk) begin
		if (reset) begin
			ctl <= '0;
		end else begin
			ctl.start <= 1'b0;

			if (wr_acc.en) begin
				if (wr_reg == REG_MBIST_3) begin
					ctl.select <= wr_acc.data[7];
					// Second request on top of a live pulse is dropped
					ctl.start <= wr_acc.data[6] && !ctl.start;
				end

				// Seed, little-endian
				else if (wr_reg >= REG_MBIST_SEED) begin
					ctl.seed[{wr_reg[1:0], 3'b000} +: 8] <= wr_acc.data;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Status readback

	always_comb begin
		rd_data = '0;
		if (rd_acc.en) begin
			case (rd_reg)
				REG_MBIST:			rd_data = status.fail_addr[7:0];
				REG_MBIST + 16'd1:	rd_data = status.fail_addr[15:8];
				REG_MBIST + 16'd2: begin
					rd_data = {{(24 - `MGMT_FAIL_ADDR_W){1'b0}},
						status.fail_addr[`MGMT_FAIL_ADDR_W-1:16]};
				end
				REG_MBIST_3:		rd_data = {ctl.select, 1'b0, status.done, status.fail, 4'b0000};
				// Seed is write only
				default:			rd_data = '0;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) ctl.start |=> !ctl.start)
		else $error("MBIST start longer than one cycle");

endmodule

/* verilog/die_info_regs.sv */
`include "mgmt_defines.svh"

module die_info_regs import mgmt_pkg::*; (
	input mgmt_access_t	rd_acc,
	input die_info_t	die_info,
	input sensor_t		sensors,
	output mgmt_data_t	rd_data,
	output logic		rd_ready
);

	// Info region starts at address zero, so the offset is the address
	mgmt_addr_t			addr;

	// Sensor words laid out so fan 0 low byte is byte 0
	logic [6*16-1:0]	sensor_bytes;

	// Byte index inside each field
	logic [1:0]			id_idx;
	logic [2:0]			ser_idx;
	logic [3:0]			sen_idx;

	assign addr = mgmt_addr_t'(rd_acc.offset);

	assign sensor_bytes = {
		sensors.volt_aux,
		sensors.volt_ram,
		sensors.volt_core,
		sensors.die_temp,
		sensors.fan1_rpm,
		sensors.fan0_rpm
	};

	assign id_idx	= 2'(addr - REG_FPGA_IDCODE);
	assign ser_idx	= 3'(addr - REG_FPGA_SERIAL);
	assign sen_idx	= 4'(addr - REG_FAN0_RPM);

	always_comb begin
		rd_data		= '0;
		rd_ready	= 1'b1;

		if (rd_acc.en) begin
			// IDCODE, top byte at the lowest address
			if (addr <= REG_FPGA_IDCODE_3) begin
				rd_data		= die_info.idcode[{2'd3 - id_idx, 3'b000} +: 8];
				rd_ready	= die_info.idcode_valid;
			end

			// Die serial, also big-endian
			else if (addr >= REG_FPGA_SERIAL && addr <= REG_FPGA_SERIAL_7) begin
				rd_data		= die_info.serial[{3'd7 - ser_idx, 3'b000} +: 8];
				rd_ready	= die_info.serial_valid;
			end

			// Sensors are little-endian and always ready
			else if (addr >= REG_FAN0_RPM && addr <= REG_VOLT_AUX_1) begin
				rd_data		= sensor_bytes[{sen_idx, 3'b000} +: 8];
			end
		end
	end

endmodule

/* verilog/mgmt_pkg.sv */
`include "mgmt_defines.svh"

package mgmt_pkg;

	typedef logic [`MGMT_DATA_W-1:0] mgmt_data_t;
	typedef logic [`MGMT_ADDR_W-1:0] mgmt_addr_t;

	// Offset inside the owning block, wide enough for port index plus register
	typedef logic [`MGMT_PORT_BITS+`MGMT_REGID_BITS-1:0] mgmt_off_t;

	// Global register map, first and last byte of each field
	typedef enum logic [`MGMT_ADDR_W-1:0] {
		REG_FPGA_IDCODE		= 16'h0000,
		REG_FPGA_IDCODE_3	= 16'h0003,
		REG_FPGA_SERIAL		= 16'h0004,
		REG_FPGA_SERIAL_7	= 16'h000b,
		REG_FAN0_RPM		= 16'h0010,
		REG_VOLT_AUX_1		= 16'h001b,
		REG_MBIST			= 16'h0040,
		REG_MBIST_3			= 16'h0043,
		REG_MBIST_SEED		= 16'h0044,
		REG_MBIST_SEED_3	= 16'h0047,
		REG_MGMT0_MDIO		= 16'h0048,
		REG_DP_MDIO			= 16'h004c,
		REG_VSC_MDIO		= 16'h0050,
		REG_VSC_MDIO_3		= 16'h0053
	} reg_id_t;

	// Offsets within one port block
	typedef enum logic [`MGMT_REGID_BITS-1:0] {
		REG_VLAN_NUM	= 10'h000,
		REG_VLAN_NUM_1	= 10'h001,
		REG_TAG_MODE	= 10'h002
	} if_off_t;

	typedef enum logic [2:0] {
		REGION_NONE,
		REGION_INFO,
		REGION_MBIST,
		REGION_MDIO,
		REGION_PORT
	} region_t;

	typedef enum logic {
		RD_IDLE,
		RD_WAIT
	} rd_state_t;

	typedef struct packed {
		logic		en;
		mgmt_off_t	offset;
		mgmt_data_t	data;
	} mgmt_access_t;

	typedef struct packed {
		logic [31:0]	idcode;
		logic			idcode_valid;
		logic [63:0]	serial;
		logic			serial_valid;
	} die_info_t;

	typedef struct packed {
		logic [15:0]	fan0_rpm;
		logic [15:0]	fan1_rpm;
		logic [15:0]	die_temp;
		logic [15:0]	volt_core;
		logic [15:0]	volt_ram;
		logic [15:0]	volt_aux;
	} sensor_t;

	typedef struct packed {
		logic [4:0]		phy_addr;
		logic [4:0]		reg_addr;
		logic [15:0]	wr_data;
		logic			rd;
		logic			wr;
	} mdio_cmd_t;

	typedef struct packed {
		logic			busy;
		logic [15:0]	rd_data;
	} mdio_status_t;

	typedef struct packed {
		logic [`MGMT_VLAN_W-1:0]	vlan;
		logic						tagged_allowed;
		logic						untagged_allowed;
		logic						is_trunk;
	} port_cfg_t;

	typedef struct packed {
		logic			start;
		logic			select;
		logic [31:0]	seed;
	} mbist_ctl_t;

	typedef struct packed {
		logic							done;
		logic							fail;
		logic [`MGMT_FAIL_ADDR_W-1:0]	fail_addr;
	} mbist_status_t;

endpackage

/* verilog/mgmt_defines.svh */
`ifndef MGMT_DEFINES_SVH
`define MGMT_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Bus geometry

// Register address and data widths
`define MGMT_ADDR_W			16
`define MGMT_DATA_W			8

//////////////////////////////////////////////////////////////////////
// Per-port configuration region

// Ports with a configuration block
`define MGMT_NUM_PORTS		15
// Port index sits above the block offset
`define MGMT_PORT_BITS		4
`define MGMT_REGID_BITS		10
// First address of the per-port region
`define MGMT_IF_BASE		16'h4000
`define MGMT_VLAN_W			12

//////////////////////////////////////////////////////////////////////
// Attached controllers

`define MGMT_NUM_MDIO		3
`define MGMT_FAIL_ADDR_W	18

`endif
